// ==== Bender.yml ====
package:
  name: branch_unit

sources:
  - bpu_pkg.sv
  - bpu_btb.sv
  - bpu_ras.sv
  - branch_resolve.sv
  - branch_unit_top.sv
  - target: test
    files:
      - tb_branch_unit.sv

// ==== bpu_btb.sv ====
`timescale 1ns/1ps

module bpu_btb #(
  parameter int BTB_ENTRIES = 16
) (
  input  logic                  clk,
  input  logic                  reset_i,
  input  logic                  lookup_valid_i,
  input  bpu_pkg::addr_t        lookup_pc_i,
  input  bpu_pkg::addr_t        ras_top_i,
  input  logic                  upd_valid_i,
  input  bpu_pkg::addr_t        upd_pc_i,
  input  logic                  upd_taken_i,
  input  bpu_pkg::addr_t        upd_target_i,
  input  bpu_pkg::target_type_t upd_target_type_i,
  output logic                  pred_valid_o,
  output logic                  pred_taken_o,
  output bpu_pkg::addr_t        pred_target_o,
  output bpu_pkg::target_type_t pred_target_type_o,
  output logic                  ras_push_o,
  output logic                  ras_pop_o,
  output bpu_pkg::addr_t        ras_push_addr_o
);

  import bpu_pkg::*;

  localparam int IDX_W = $clog2(BTB_ENTRIES);
  localparam int TAG_W = 30 - IDX_W;

  logic [BTB_ENTRIES-1:0] entry_valid_q;
  logic [TAG_W-1:0]       tag_q    [BTB_ENTRIES];
  addr_t                  target_q [BTB_ENTRIES];
  target_type_t           type_q   [BTB_ENTRIES];
  counter_t               cnt_q    [BTB_ENTRIES];

  logic [IDX_W-1:0] lookup_idx;
  logic [TAG_W-1:0] lookup_tag;
  logic             lookup_hit;
  logic [IDX_W-1:0] upd_idx;
  logic [TAG_W-1:0] upd_tag;
  logic             upd_hit;
  counter_t         upd_cnt_base;
  counter_t         upd_cnt_next;

  logic         out_valid_q;
  target_type_t out_type_q;
  counter_t     out_cnt_q;
  addr_t        out_target_q;
  addr_t        out_pc_q;
  logic         out_taken;

  // pc bits 1..0 are always zero, the index sits right above them
  assign lookup_idx = lookup_pc_i[IDX_W+1:2];
  assign lookup_tag = lookup_pc_i[31:IDX_W+2];
  assign lookup_hit = entry_valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);

  assign upd_idx = upd_pc_i[IDX_W+1:2];
  assign upd_tag = upd_pc_i[31:IDX_W+2];
  assign upd_hit = entry_valid_q[upd_idx] && (tag_q[upd_idx] == upd_tag);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // training
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // a replaced or new entry restarts from weakly not taken before saturating
  always_comb begin
    upd_cnt_base = upd_hit ? cnt_q[upd_idx] : COUNTER_WEAK_NT;
    upd_cnt_next = upd_cnt_base;
    if (upd_taken_i) begin
      if (upd_cnt_base != COUNTER_STRONG_T) begin
        upd_cnt_next = upd_cnt_base + 2'd1;
      end
    end else if (upd_cnt_base != COUNTER_STRONG_NT) begin
      upd_cnt_next = upd_cnt_base - 2'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      entry_valid_q <= '0;
    end else if (upd_valid_i) begin
      entry_valid_q[upd_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (upd_valid_i) begin
      tag_q[upd_idx]    <= upd_tag;
      target_q[upd_idx] <= upd_target_i;
      type_q[upd_idx]   <= upd_target_type_i;
      cnt_q[upd_idx]    <= upd_cnt_next;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // lookup stage
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // a miss or an idle cycle registers the fall-through type
  always_ff @(posedge clk) begin
    if (reset_i) begin
      out_valid_q <= 1'b0;
      out_type_q  <= TARGET_NPC;
    end else begin
      out_valid_q <= lookup_valid_i;
      out_type_q  <= (lookup_valid_i && lookup_hit) ? type_q[lookup_idx] : TARGET_NPC;
    end
  end

  always_ff @(posedge clk) begin
    out_cnt_q    <= cnt_q[lookup_idx];
    out_target_q <= lookup_hit ? target_q[lookup_idx] : lookup_pc_i + 32'd4;
    out_pc_q     <= lookup_pc_i;
  end

  // only immediate branches consult the counter
  always_comb begin
    unique case (out_type_q)
      TARGET_CALL, TARGET_RETURN: out_taken = 1'b1;
      TARGET_IMM:                 out_taken = (out_cnt_q >= COUNTER_WEAK_T);
      default:                    out_taken = 1'b0;
    endcase
  end

  assign pred_valid_o       = out_valid_q;
  assign pred_taken_o       = out_taken;
  assign pred_target_type_o = out_type_q;
  assign pred_target_o      = (out_type_q == TARGET_RETURN) ? ras_top_i : out_target_q;

  // the stack moves in the same cycle the prediction leaves
  assign ras_push_o      = out_valid_q && (out_type_q == TARGET_CALL);
  assign ras_pop_o       = out_valid_q && (out_type_q == TARGET_RETURN);
  assign ras_push_addr_o = out_pc_q + 32'd4;

endmodule

// ==== bpu_pkg.sv ====
package bpu_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // widths shared by the predictor, the return stack and the resolver
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // a pc or a branch target
  typedef logic [31:0] addr_t;

  // bit 0 selects a signed compare and bits 3..1 enable lt, eq and gt
  // all three enables set means the transfer is always taken
  typedef logic [3:0] cmp_type_t;

  // kind of control transfer the buffer remembers per entry
  typedef logic [1:0] target_type_t;

  // 2-bit saturating direction counter
  typedef logic [1:0] counter_t;

  // position of the signed select inside the compare code
  localparam int CMP_SIGNED_BIT = 0;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // target type encodings
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam target_type_t TARGET_NPC    = 2'd0;
  localparam target_type_t TARGET_CALL   = 2'd1;
  localparam target_type_t TARGET_RETURN = 2'd2;
  localparam target_type_t TARGET_IMM    = 2'd3;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // counter states
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam counter_t COUNTER_STRONG_NT = 2'd0;
  // a freshly allocated entry starts here
  localparam counter_t COUNTER_WEAK_NT   = 2'd1;
  // this value and above predict taken
  localparam counter_t COUNTER_WEAK_T    = 2'd2;
  localparam counter_t COUNTER_STRONG_T  = 2'd3;

endpackage

// ==== bpu_ras.sv ====
`timescale 1ns/1ps

module bpu_ras #(
  parameter int RAS_DEPTH = 8
) (
  input  logic                         clk,
  input  logic                         reset_i,
  input  logic                         push_i,
  input  logic                         pop_i,
  input  bpu_pkg::addr_t               push_addr_i,
  input  logic                         restore_i,
  input  logic [$clog2(RAS_DEPTH)-1:0] restore_ptr_i,
  output bpu_pkg::addr_t               top_o,
  output logic [$clog2(RAS_DEPTH)-1:0] ptr_o
);

  import bpu_pkg::*;

  localparam int PTR_W = $clog2(RAS_DEPTH);

  addr_t            stack_q [RAS_DEPTH];
  logic [PTR_W-1:0] ptr_q;
  logic [PTR_W-1:0] ptr_spec;
  logic [PTR_W-1:0] top_idx;

  // the pointer names the next free slot, so the top is one below it
  assign top_idx = ptr_q - PTR_W'(1);
  assign top_o   = stack_q[top_idx];

  // pointer as seen by the prediction leaving this cycle
  always_comb begin
    ptr_spec = ptr_q;
    if (push_i) begin
      ptr_spec = ptr_q + PTR_W'(1);
    end else if (pop_i) begin
      ptr_spec = ptr_q - PTR_W'(1);
    end
  end

  assign ptr_o = ptr_spec;

  // a restore from the resolver overrides any speculative move
  always_ff @(posedge clk) begin
    if (reset_i) begin
      ptr_q <= '0;
    end else if (restore_i) begin
      ptr_q <= restore_ptr_i;
    end else begin
      ptr_q <= ptr_spec;
    end
  end

  // repair is pointer only and the stored addresses stay put
  always_ff @(posedge clk) begin
    if (push_i && !restore_i) begin
      stack_q[ptr_q] <= push_addr_i;
    end
  end

endmodule

// ==== branch_resolve.sv ====
`timescale 1ns/1ps

module branch_resolve #(
  parameter int RAS_DEPTH = 8
) (
  input  logic                         resolve_valid_i,
  input  bpu_pkg::addr_t               resolve_pc_i,
  input  bpu_pkg::addr_t               resolve_target_i,
  input  bpu_pkg::target_type_t        resolve_target_type_i,
  input  bpu_pkg::cmp_type_t           resolve_cmp_type_i,
  input  logic [31:0]                  resolve_rs1_i,
  input  logic [31:0]                  resolve_rs2_i,
  input  logic                         resolve_pred_taken_i,
  input  bpu_pkg::addr_t               resolve_pred_target_i,
  input  logic [$clog2(RAS_DEPTH)-1:0] resolve_pred_ras_ptr_i,
  output logic                         redirect_o,
  output bpu_pkg::addr_t               redirect_pc_o,
  output logic                         upd_valid_o,
  output logic                         upd_taken_o,
  output bpu_pkg::addr_t               upd_pc_o,
  output bpu_pkg::addr_t               upd_target_o,
  output bpu_pkg::target_type_t        upd_target_type_o,
  output logic                         ras_restore_o,
  output logic [$clog2(RAS_DEPTH)-1:0] ras_restore_ptr_o
);

  import bpu_pkg::*;

  localparam int PTR_W = $clog2(RAS_DEPTH);

  logic        ext_bit1;
  logic        ext_bit2;
  logic [32:0] rs1_ext;
  logic [32:0] rs2_ext;
  logic [3:1]  cmp_hit;
  logic        true_taken;
  logic        dir_miss;
  logic        target_miss;
  logic        mispredict;
  addr_t       next_pc;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // direction
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // flipping the sign bit into a 33rd bit lets one unsigned compare serve both
  assign ext_bit1 = ~resolve_rs1_i[31] & resolve_cmp_type_i[CMP_SIGNED_BIT];
  assign ext_bit2 = ~resolve_rs2_i[31] & resolve_cmp_type_i[CMP_SIGNED_BIT];
  assign rs1_ext  = {ext_bit1, resolve_rs1_i};
  assign rs2_ext  = {ext_bit2, resolve_rs2_i};

  // bit 3 is rs1 < rs2, bit 2 equal, bit 1 rs1 > rs2
  assign cmp_hit[3] = rs1_ext < rs2_ext;
  assign cmp_hit[2] = rs1_ext == rs2_ext;
  assign cmp_hit[1] = rs1_ext > rs2_ext;

  assign true_taken = |(cmp_hit & resolve_cmp_type_i[3:1]);
  assign next_pc    = true_taken ? resolve_target_i : resolve_pc_i + 32'd4;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // misprediction and training
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign dir_miss    = resolve_pred_taken_i != true_taken;
  assign target_miss = resolve_pred_taken_i && true_taken &&
                       (resolve_pred_target_i != resolve_target_i);
  assign mispredict  = resolve_valid_i && (dir_miss || target_miss);

  assign redirect_o    = mispredict;
  assign redirect_pc_o = next_pc;

  assign upd_valid_o       = resolve_valid_i && (resolve_target_type_i != TARGET_NPC);
  assign upd_taken_o       = true_taken;
  assign upd_pc_o          = resolve_pc_i;
  assign upd_target_o      = resolve_target_i;
  assign upd_target_type_o = resolve_target_type_i;

  // the corrected pointer accounts for this instruction's own push or pop
  always_comb begin
    ras_restore_ptr_o = resolve_pred_ras_ptr_i;
    if (resolve_target_type_i == TARGET_CALL) begin
      ras_restore_ptr_o = resolve_pred_ras_ptr_i + PTR_W'(1);
    end else if (resolve_target_type_i == TARGET_RETURN) begin
      ras_restore_ptr_o = resolve_pred_ras_ptr_i - PTR_W'(1);
    end
  end

  assign ras_restore_o = mispredict;

endmodule

// ==== branch_unit_top.sv ====
`timescale 1ns/1ps

module branch_unit_top #(
  parameter int BTB_ENTRIES = 16,
  parameter int RAS_DEPTH   = 8
) (
  input  logic                         clk,
  input  logic                         reset_i,
  input  logic                         lookup_valid_i,
  input  bpu_pkg::addr_t               lookup_pc_i,
  input  logic                         resolve_valid_i,
  input  bpu_pkg::addr_t               resolve_pc_i,
  input  bpu_pkg::addr_t               resolve_target_i,
  input  bpu_pkg::target_type_t        resolve_target_type_i,
  input  bpu_pkg::cmp_type_t           resolve_cmp_type_i,
  input  logic [31:0]                  resolve_rs1_i,
  input  logic [31:0]                  resolve_rs2_i,
  input  logic                         resolve_pred_taken_i,
  input  bpu_pkg::addr_t               resolve_pred_target_i,
  input  logic [$clog2(RAS_DEPTH)-1:0] resolve_pred_ras_ptr_i,
  output logic                         pred_valid_o,
  output logic                         pred_taken_o,
  output bpu_pkg::addr_t               pred_target_o,
  output bpu_pkg::target_type_t        pred_target_type_o,
  output logic [$clog2(RAS_DEPTH)-1:0] pred_ras_ptr_o,
  output logic                         redirect_o,
  output bpu_pkg::addr_t               redirect_pc_o
);

  import bpu_pkg::*;

  localparam int PTR_W = $clog2(RAS_DEPTH);

  // prediction side to the stack
  logic             ras_push;
  logic             ras_pop;
  addr_t            ras_push_addr;
  addr_t            ras_top;
  // resolver feedback
  logic             upd_valid;
  logic             upd_taken;
  addr_t            upd_pc;
  addr_t            upd_target;
  target_type_t     upd_target_type;
  logic             ras_restore;
  logic [PTR_W-1:0] ras_restore_ptr;

  bpu_btb #(.BTB_ENTRIES(BTB_ENTRIES)) btb0 (
    .clk, .reset_i, .lookup_valid_i, .lookup_pc_i,
    .ras_top_i(ras_top), .upd_valid_i(upd_valid), .upd_pc_i(upd_pc),
    .upd_taken_i(upd_taken), .upd_target_i(upd_target),
    .upd_target_type_i(upd_target_type),
    .pred_valid_o, .pred_taken_o, .pred_target_o, .pred_target_type_o,
    .ras_push_o(ras_push), .ras_pop_o(ras_pop), .ras_push_addr_o(ras_push_addr)
  );

  bpu_ras #(.RAS_DEPTH(RAS_DEPTH)) ras0 (
    .clk, .reset_i, .push_i(ras_push), .pop_i(ras_pop), .push_addr_i(ras_push_addr),
    .restore_i(ras_restore), .restore_ptr_i(ras_restore_ptr),
    .top_o(ras_top), .ptr_o(pred_ras_ptr_o)
  );

  branch_resolve #(.RAS_DEPTH(RAS_DEPTH)) resolve0 (
    .resolve_valid_i, .resolve_pc_i, .resolve_target_i, .resolve_target_type_i,
    .resolve_cmp_type_i, .resolve_rs1_i, .resolve_rs2_i, .resolve_pred_taken_i,
    .resolve_pred_target_i, .resolve_pred_ras_ptr_i, .redirect_o, .redirect_pc_o,
    .upd_valid_o(upd_valid), .upd_taken_o(upd_taken), .upd_pc_o(upd_pc),
    .upd_target_o(upd_target), .upd_target_type_o(upd_target_type),
    .ras_restore_o(ras_restore), .ras_restore_ptr_o(ras_restore_ptr)
  );

endmodule

// ==== tb_branch_unit.sv ====
`timescale 1ns/1ps

module tb_branch_unit;

  import bpu_pkg::*;

  localparam int RAS_DEPTH   = 8;
  localparam int PTR_W       = $clog2(RAS_DEPTH);
  localparam int N_RANDOM    = 32;
  // reset, idle, directed sequences and both random loops
  localparam int STIM_CYCLES = 28 + 2 * N_RANDOM;
  localparam int MARGIN      = 40;

  logic             clk;
  logic             reset_i;
  logic             lookup_valid_i;
  addr_t            lookup_pc_i;
  logic             resolve_valid_i;
  addr_t            resolve_pc_i;
  addr_t            resolve_target_i;
  target_type_t     resolve_target_type_i;
  cmp_type_t        resolve_cmp_type_i;
  logic [31:0]      resolve_rs1_i;
  logic [31:0]      resolve_rs2_i;
  logic             resolve_pred_taken_i;
  addr_t            resolve_pred_target_i;
  logic [PTR_W-1:0] resolve_pred_ras_ptr_i;
  logic             pred_valid_o;
  logic             pred_taken_o;
  addr_t            pred_target_o;
  target_type_t     pred_target_type_o;
  logic [PTR_W-1:0] pred_ras_ptr_o;
  logic             redirect_o;
  addr_t            redirect_pc_o;

  int               errors = 0;
  int               checks = 0;
  logic [31:0]      lfsr_q = 32'hc36e;
  // stack pointer as the reference model expects it
  logic [PTR_W-1:0] ptr_model = '0;

  branch_unit_top dut0 (.*);

  always #10 clk = ~clk;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model and helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // one LFSR step for every bit handed out
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  function automatic logic model_taken(input cmp_type_t cmp, input logic [31:0] a,
                                       input logic [31:0] b);
    logic lt;
    logic gt;
    if (cmp[0]) begin
      lt = $signed(a) < $signed(b);
      gt = $signed(a) > $signed(b);
    end else begin
      lt = a < b;
      gt = a > b;
    end
    return (cmp[3] && lt) || (cmp[2] && (a == b)) || (cmp[1] && gt);
  endfunction

  // a call moves the pointer up by one and a return moves it down
  function automatic logic [PTR_W-1:0] step_ptr(input logic [PTR_W-1:0] p,
                                                input target_type_t t);
    if (t == TARGET_CALL) return p + 1'b1;
    if (t == TARGET_RETURN) return p - 1'b1;
    return p;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAIL %s expected 0x%08h got 0x%08h", name, exp, got);
    end
  endtask

  task automatic idle_check();
    @(posedge clk);
    lookup_valid_i  <= 1'b0;
    resolve_valid_i <= 1'b0;
    @(negedge clk);
    check_value("pred_valid_o", 1'b0, pred_valid_o);
    check_value("redirect_o", 1'b0, redirect_o);
  endtask

  task automatic lookup(input addr_t pc, input logic exp_taken, input target_type_t exp_type,
                        input logic use_target, input addr_t exp_target);
    @(posedge clk);
    lookup_valid_i  <= 1'b1;
    lookup_pc_i     <= pc;
    resolve_valid_i <= 1'b0;
    @(posedge clk);
    lookup_valid_i <= 1'b0;
    @(negedge clk);
    ptr_model = step_ptr(ptr_model, exp_type);
    checks++;
    assert (pred_valid_o === 1'b1) else begin
      errors++;
      $display("no prediction came back one cycle after the lookup of pc 0x%08h", pc);
    end
    check_value("pred_taken_o", exp_taken, pred_taken_o);
    check_value("pred_target_type_o", exp_type, pred_target_type_o);
    if (use_target) check_value("pred_target_o", exp_target, pred_target_o);
    check_value("pred_ras_ptr_o", ptr_model, pred_ras_ptr_o);
  endtask

  task automatic resolve(input addr_t pc, input addr_t target, input target_type_t ttype,
                         input cmp_type_t cmp, input logic [31:0] rs1, input logic [31:0] rs2,
                         input logic p_taken, input addr_t p_target);
    logic  exp_taken;
    logic  exp_miss;
    addr_t exp_pc;
    exp_taken = model_taken(cmp, rs1, rs2);
    exp_pc    = exp_taken ? target : pc + 32'd4;
    exp_miss  = (p_taken != exp_taken) || (p_taken && exp_taken && (p_target != target));
    @(posedge clk);
    lookup_valid_i         <= 1'b0;
    resolve_valid_i        <= 1'b1;
    resolve_pc_i           <= pc;
    resolve_target_i       <= target;
    resolve_target_type_i  <= ttype;
    resolve_cmp_type_i     <= cmp;
    resolve_rs1_i          <= rs1;
    resolve_rs2_i          <= rs2;
    resolve_pred_taken_i   <= p_taken;
    resolve_pred_target_i  <= p_target;
    resolve_pred_ras_ptr_i <= ptr_model;
    @(negedge clk);
    check_value("redirect_o", exp_miss, redirect_o);
    check_value("redirect_pc_o", exp_pc, redirect_pc_o);
    if (exp_miss) ptr_model = step_ptr(ptr_model, ttype);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // protocol checks that hold in every cycle
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assert property (@(posedge clk) disable iff (reset_i) !resolve_valid_i |-> !redirect_o)
    else begin
      errors++;
      $display("redirect was raised in a cycle without a resolve");
    end

  assert property (@(posedge clk) disable iff (reset_i) pred_valid_o |-> $past(lookup_valid_i))
    else begin
      errors++;
      $display("a prediction appeared without a lookup in the cycle before");
    end

  initial begin
    #((STIM_CYCLES + MARGIN) * 20);
    $display("watchdog expired before the stimulus finished");
    $display("Test failed");
    $finish;
  end

  initial begin
    logic [31:0]      r;
    logic [31:0]      rs1;
    logic [31:0]      rs2;
    logic [31:0]      pc;
    logic [31:0]      tgt;
    logic [31:0]      base;
    logic [31:0]      sel;
    logic [PTR_W-1:0] exp_ptr;
    clk = 1'b0;
    reset_i = 1'b1;
    lookup_valid_i = 1'b0;
    lookup_pc_i = '0;
    resolve_valid_i = 1'b0;
    resolve_pc_i = '0;
    resolve_target_i = '0;
    resolve_target_type_i = TARGET_NPC;
    resolve_cmp_type_i = '0;
    resolve_rs1_i = '0;
    resolve_rs2_i = '0;
    resolve_pred_taken_i = 1'b0;
    resolve_pred_target_i = '0;
    resolve_pred_ras_ptr_i = '0;
    repeat (4) @(posedge clk);
    reset_i <= 1'b0;

    // quiet outputs after reset, then a cold miss
    repeat (3) idle_check();
    take_bits(32, base);
    base = base & ~32'h3;
    lookup(base + 32'h40, 1'b0, TARGET_NPC, 1'b0, '0);

    // random compares with a not-taken prediction
    for (int i = 0; i < N_RANDOM; i++) begin
      take_bits(4, r);
      take_bits(32, rs1);
      take_bits(32, rs2);
      take_bits(1, pc);
      if (pc[0]) rs2 = rs1;
      take_bits(32, pc);
      take_bits(32, tgt);
      resolve(pc & ~32'h3, tgt & ~32'h3, TARGET_NPC, r[3:0], rs1, rs2, 1'b0, '0);
    end

    // random predictions against the true outcome
    for (int i = 0; i < N_RANDOM; i++) begin
      take_bits(4, r);
      take_bits(32, rs1);
      take_bits(32, rs2);
      take_bits(32, pc);
      take_bits(32, tgt);
      tgt = tgt & ~32'h3;
      take_bits(2, sel);
      resolve(pc & ~32'h3, tgt, TARGET_NPC, r[3:0], rs1, rs2, sel[0],
              sel[1] ? tgt ^ 32'h10 : tgt);
    end
    resolve(base + 32'h80, 32'h1000, TARGET_NPC, 4'b1110, 0, 0, 1'b1, 32'h2000);

    // training of an immediate branch
    resolve(base, base + 32'h100, TARGET_IMM, 4'b1110, 0, 0, 1'b0, '0);
    lookup(base, 1'b1, TARGET_IMM, 1'b1, base + 32'h100);
    resolve(base, base + 32'h100, TARGET_IMM, 4'b0100, 1, 2, 1'b1, base + 32'h100);
    resolve(base, base + 32'h100, TARGET_IMM, 4'b0100, 1, 2, 1'b1, base + 32'h100);
    lookup(base, 1'b0, TARGET_IMM, 1'b0, '0);

    // a call at base + 4 and a return at base + 8
    resolve(base + 32'h4, 32'h3000, TARGET_CALL, 4'b1110, 0, 0, 1'b1, 32'h3000);
    resolve(base + 32'h8, 32'h5000, TARGET_RETURN, 4'b1110, 0, 0, 1'b1, 32'h5000);
    lookup(base + 32'h4, 1'b1, TARGET_CALL, 1'b1, 32'h3000);
    lookup(base + 32'h8, 1'b1, TARGET_RETURN, 1'b1, base + 32'h8);

    // mispredicted call restores the pointer to its own push
    take_bits(PTR_W, r);
    ptr_model = r[PTR_W-1:0];
    // the pointer wraps at the stack depth
    exp_ptr = r[PTR_W-1:0] + 2'd2;
    resolve(base + 32'h4, 32'h3000, TARGET_CALL, 4'b1110, 0, 0, 1'b0, '0);
    lookup(base + 32'h4, 1'b1, TARGET_CALL, 1'b1, 32'h3000);
    check_value("pred_ras_ptr_o", exp_ptr, pred_ras_ptr_o);

    repeat (2) idle_check();
    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
bpu_pkg.sv
bpu_btb.sv
bpu_ras.sv
branch_resolve.sv
branch_unit_top.sv
tb_branch_unit.sv
